/* tb.f */
logic/cpu_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/ram.sv
logic/exec_unit.sv
logic/cpu_top.sv
bench/cpu_tb.sv

/* Makefile */
TOP := cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --timescale 1ns/100ps \
		-f tb.f --top-module cpu_top

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* bench/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    localparam int NUM_TESTS     = 6;
    localparam int MAX_INSTR     = 12;
    localparam int MAX_DATA      = 4;
    localparam int MAX_STORES    = 8;
    localparam int CLK_PERIOD    = 8;
    localparam int CYCLES_INSTR  = 6;
    // Reset, host loading and the idle cycles after HALT, per test
    localparam int MARGIN_CYCLES = 100;
    localparam int DRAIN_CYCLES  = 8;

    logic           clk;
    logic           reset;
    logic           start;
    logic           halted;
    logic           host_we;
    cpu_pkg::addr_t host_addr;
    cpu_pkg::data_t host_wdata;
    logic           store_valid;
    cpu_pkg::addr_t store_addr;
    cpu_pkg::data_t store_data;

    // Test table of program words, preloaded bytes and expected store trace
    cpu_pkg::instr_t prog      [NUM_TESTS][MAX_INSTR];
    int              prog_len  [NUM_TESTS];
    cpu_pkg::addr_t  data_addr [NUM_TESTS][MAX_DATA];
    cpu_pkg::data_t  data_val  [NUM_TESTS][MAX_DATA];
    int              data_len  [NUM_TESTS];
    cpu_pkg::addr_t  exp_addr  [NUM_TESTS][MAX_STORES];
    cpu_pkg::data_t  exp_data  [NUM_TESTS][MAX_STORES];
    int              exp_len   [NUM_TESTS];

    logic [31:0]     rng_state;
    bit              table_ready = 1'b0;
    int              current_test;

    cpu_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .halted      (halted),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Register form with spare bits 11, 7 and 3 left zero
    function automatic cpu_pkg::instr_t encode_regs(input logic [3:0] op, input int rd,
                                                   input int rs, input int rt);
        return {op, 1'b0, cpu_pkg::reg_addr_t'(rd), 1'b0, cpu_pkg::reg_addr_t'(rs),
                1'b0, cpu_pkg::reg_addr_t'(rt)};
    endfunction

    // Immediate or address in the low byte
    function automatic cpu_pkg::instr_t encode_imm(input logic [3:0] op, input int rd,
                                                  input cpu_pkg::data_t imm);
        return {op, 1'b0, cpu_pkg::reg_addr_t'(rd), imm};
    endfunction

    task automatic random_byte(output cpu_pkg::data_t value);
        rng_state = xorshift32(rng_state);
        value = rng_state[7:0];
    endtask

    task automatic add_instr(input int t, input cpu_pkg::instr_t word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic add_data(input int t, input cpu_pkg::addr_t addr,
                            input cpu_pkg::data_t value);
        data_addr[t][data_len[t]] = addr;
        data_val[t][data_len[t]]  = value;
        data_len[t]++;
    endtask

    task automatic add_store(input int t, input cpu_pkg::addr_t addr,
                             input cpu_pkg::data_t value);
        exp_addr[t][exp_len[t]] = addr;
        exp_data[t][exp_len[t]] = value;
        exp_len[t]++;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: test %0d %s = 0x%0h, expected 0x%0h",
                     current_test, name, actual, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic build_tests();
        cpu_pkg::data_t a;
        cpu_pkg::data_t b;
        cpu_pkg::data_t c;
        cpu_pkg::data_t d;
        cpu_pkg::data_t sum_ab;
        cpu_pkg::data_t diff_ab;
        cpu_pkg::data_t sum_ac;
        cpu_pkg::data_t diff_bd;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            data_len[t] = 0;
            exp_len[t]  = 0;
        end
        rng_state = 32'd27;

        // Immediate moves stored straight out
        add_instr(0, encode_imm(cpu_pkg::MOVIR, 1, 8'h3C));
        add_instr(0, encode_imm(cpu_pkg::STORE, 1, 8'h80));
        add_instr(0, encode_imm(cpu_pkg::MOVIR, 2, 8'hC5));
        add_instr(0, encode_imm(cpu_pkg::STORE, 2, 8'h81));
        add_instr(0, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_store(0, 8'h80, 8'h3C);
        add_store(0, 8'h81, 8'hC5);

        // Arithmetic on random operands with expected values wrapped at 256
        random_byte(a);
        random_byte(b);
        random_byte(c);
        random_byte(d);
        sum_ab  = cpu_pkg::data_t'((int'(a) + int'(b)) % 256);
        diff_ab = cpu_pkg::data_t'((int'(a) - int'(b) + 256) % 256);
        sum_ac  = cpu_pkg::data_t'((int'(a) + int'(c)) % 256);
        diff_bd = cpu_pkg::data_t'((int'(b) - int'(d) + 256) % 256);
        add_instr(1, encode_imm(cpu_pkg::MOVIR, 1, a));
        add_instr(1, encode_imm(cpu_pkg::MOVIR, 2, b));
        add_instr(1, encode_regs(cpu_pkg::ADDRR, 3, 1, 2));
        add_instr(1, encode_regs(cpu_pkg::SUBRR, 4, 1, 2));
        add_instr(1, encode_imm(cpu_pkg::ADDI, 1, c));
        add_instr(1, encode_imm(cpu_pkg::SUBI, 2, d));
        // ADDRR result reaches memory through the MOVRR copy
        add_instr(1, encode_regs(cpu_pkg::MOVRR, 5, 3, 0));
        add_instr(1, encode_imm(cpu_pkg::STORE, 4, 8'h91));
        add_instr(1, encode_imm(cpu_pkg::STORE, 1, 8'h92));
        add_instr(1, encode_imm(cpu_pkg::STORE, 2, 8'h93));
        add_instr(1, encode_imm(cpu_pkg::STORE, 5, 8'h94));
        add_instr(1, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_store(1, 8'h91, diff_ab);
        add_store(1, 8'h92, sum_ac);
        add_store(1, 8'h93, diff_bd);
        add_store(1, 8'h94, sum_ab);

        // Loads of host-preloaded bytes copied elsewhere
        add_data(2, 8'hA0, 8'h5E);
        add_data(2, 8'hA1, 8'hE7);
        add_instr(2, encode_imm(cpu_pkg::LOAD, 6, 8'hA0));
        add_instr(2, encode_imm(cpu_pkg::STORE, 6, 8'hB0));
        add_instr(2, encode_imm(cpu_pkg::LOAD, 7, 8'hA1));
        add_instr(2, encode_imm(cpu_pkg::STORE, 7, 8'hB1));
        add_instr(2, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_store(2, 8'hB0, 8'h5E);
        add_store(2, 8'hB1, 8'hE7);

        // JZI taken to word 5 (0x0A) and then not taken
        add_instr(3, encode_imm(cpu_pkg::MOVIR, 1, 8'h05));
        add_instr(3, encode_imm(cpu_pkg::SUBI, 1, 8'h05));
        add_instr(3, encode_imm(cpu_pkg::JZI, 0, 8'h0A));
        add_instr(3, encode_imm(cpu_pkg::MOVIR, 2, 8'h11));
        add_instr(3, encode_imm(cpu_pkg::STORE, 2, 8'hC0));
        add_instr(3, encode_imm(cpu_pkg::ADDI, 1, 8'h01));
        add_instr(3, encode_imm(cpu_pkg::JZI, 0, 8'h12));
        add_instr(3, encode_imm(cpu_pkg::STORE, 1, 8'hC1));
        add_instr(3, encode_imm(cpu_pkg::STORE, 1, 8'hC2));
        add_instr(3, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_store(3, 8'hC1, 8'h01);
        add_store(3, 8'hC2, 8'h01);

        // JZR through r4 = 0x10 to word 8
        add_instr(4, encode_imm(cpu_pkg::MOVIR, 4, 8'h10));
        add_instr(4, encode_imm(cpu_pkg::MOVIR, 1, 8'h07));
        add_instr(4, encode_imm(cpu_pkg::ADDI, 1, 8'h00));
        add_instr(4, encode_imm(cpu_pkg::JZR, 4, 8'h00));
        add_instr(4, encode_imm(cpu_pkg::STORE, 1, 8'hD0));
        add_instr(4, encode_regs(cpu_pkg::SUBRR, 2, 1, 1));
        add_instr(4, encode_imm(cpu_pkg::JZR, 4, 8'h00));
        add_instr(4, encode_imm(cpu_pkg::STORE, 1, 8'hD1));
        add_instr(4, encode_imm(cpu_pkg::STORE, 2, 8'hD2));
        add_instr(4, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_store(4, 8'hD0, 8'h07);
        add_store(4, 8'hD2, 8'h00);

        // Unassigned codes name r1 as rd but must leave it alone
        add_instr(5, encode_imm(cpu_pkg::MOVIR, 1, 8'h99));
        add_instr(5, encode_imm(4'd11, 1, 8'hFF));
        add_instr(5, encode_imm(4'd12, 1, 8'h00));
        add_instr(5, encode_imm(cpu_pkg::NOP, 1, 8'h42));
        add_instr(5, encode_imm(4'd14, 1, 8'h5A));
        add_instr(5, encode_imm(cpu_pkg::STORE, 1, 8'hE0));
        add_instr(5, encode_imm(cpu_pkg::HALT, 0, 8'h00));
        add_instr(5, encode_imm(cpu_pkg::STORE, 1, 8'hE1));
        add_store(5, 8'hE0, 8'h99);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Core must stay quiet while the host loads
    task automatic host_write(input cpu_pkg::addr_t addr, input cpu_pkg::data_t value);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= value;
        @(negedge clk);
        check_value("store_valid", 32'(store_valid), 32'd0);
        check_value("halted", 32'(halted), 32'd0);
    endtask

    // Big-endian words with the high byte at the even address
    task automatic load_program(input int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            host_write(cpu_pkg::addr_t'(2 * i), prog[t][i][15:8]);
            host_write(cpu_pkg::addr_t'(2 * i + 1), prog[t][i][7:0]);
        end
        for (int i = 0; i < data_len[t]; i++) begin
            host_write(data_addr[t][i], data_val[t][i]);
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic collect_stores(input int t);
        int count;
        count = 0;
        while (halted !== 1'b1) begin
            @(negedge clk);
            if (store_valid === 1'b1) begin
                if (count >= exp_len[t]) begin
                    check_value("store_valid", 32'(store_valid), 32'd0);
                end else begin
                    check_value("store_addr", 32'(store_addr), 32'(exp_addr[t][count]));
                    check_value("store_data", 32'(store_data), 32'(exp_data[t][count]));
                end
                count++;
            end
        end
        check_value("store_count", 32'(count), 32'(exp_len[t]));
        // Halted holds and nothing is written after HALT
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            check_value("store_valid", 32'(store_valid), 32'd0);
            check_value("halted", 32'(halted), 32'd1);
        end
    endtask

    initial begin : watchdog
        int total_instr;
        int limit_ns;
        wait (table_ready);
        total_instr = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_instr += prog_len[t];
        end
        limit_ns = (total_instr * CYCLES_INSTR + NUM_TESTS * MARGIN_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog: simulation timed out after %0d ns", limit_ns);
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin : main
        reset        = 1'b1;
        start        = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        current_test = 0;
        build_tests();
        table_ready = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            current_test = t;
            apply_reset();
            load_program(t);
            pulse_start();
            collect_stores(t);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            start,
    output wire logic            halted,

    input  wire logic            host_we,
    input  wire cpu_pkg::addr_t  host_addr,
    input  wire cpu_pkg::data_t  host_wdata,

    // Store trace is the core's RAM write port
    output wire logic            store_valid,
    output wire cpu_pkg::addr_t  store_addr,
    output wire cpu_pkg::data_t  store_data
);

    wire logic               mem_re;
    wire cpu_pkg::data_t     mem_rdata;

    wire logic               rd0_en;
    wire cpu_pkg::reg_addr_t rd0_addr;
    wire cpu_pkg::data_t     rd0_data;
    wire logic               rd1_en;
    wire cpu_pkg::reg_addr_t rd1_addr;
    wire cpu_pkg::data_t     rd1_data;
    wire logic               wr_en;
    wire cpu_pkg::reg_addr_t wr_addr;
    wire cpu_pkg::data_t     wr_data;

    wire cpu_pkg::data_t     alu_b;
    wire logic               alu_subtract;
    wire cpu_pkg::data_t     alu_result;
    wire logic               alu_zero;

    exec_unit exec_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .halted       (halted),
        .mem_addr     (store_addr),
        .mem_re       (mem_re),
        .mem_we       (store_valid),
        .mem_wdata    (store_data),
        .mem_rdata    (mem_rdata),
        .rd0_en       (rd0_en),
        .rd0_addr     (rd0_addr),
        .rd0_data     (rd0_data),
        .rd1_en       (rd1_en),
        .rd1_addr     (rd1_addr),
        .rd1_data     (rd1_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .alu_b        (alu_b),
        .alu_subtract (alu_subtract),
        .alu_result   (alu_result),
        .alu_zero     (alu_zero)
    );

    alu alu_i (
        .a        (rd0_data),
        .b        (alu_b),
        .subtract (alu_subtract),
        .result   (alu_result),
        .zero     (alu_zero)
    );

    register_file regs_i (
        .clk      (clk),
        .reset    (reset),
        .rd0_en   (rd0_en),
        .rd0_addr (rd0_addr),
        .rd0_data (rd0_data),
        .rd1_en   (rd1_en),
        .rd1_addr (rd1_addr),
        .rd1_data (rd1_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    ram ram_i (
        .clk        (clk),
        .addr       (store_addr),
        .re         (mem_re),
        .we         (store_valid),
        .wdata      (store_data),
        .rdata      (mem_rdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata)
    );

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start,
    output logic                       halted,

    // RAM core port
    output cpu_pkg::addr_t             mem_addr,
    output logic                       mem_re,
    output logic                       mem_we,
    output cpu_pkg::data_t             mem_wdata,
    input  wire cpu_pkg::data_t        mem_rdata,

    // Register file
    output logic                       rd0_en,
    output cpu_pkg::reg_addr_t         rd0_addr,
    input  wire cpu_pkg::data_t        rd0_data,
    output logic                       rd1_en,
    output cpu_pkg::reg_addr_t         rd1_addr,
    input  wire cpu_pkg::data_t        rd1_data,
    output logic                       wr_en,
    output cpu_pkg::reg_addr_t         wr_addr,
    output cpu_pkg::data_t             wr_data,

    // ALU operand B, control and result
    output cpu_pkg::data_t             alu_b,
    output logic                       alu_subtract,
    input  wire cpu_pkg::data_t        alu_result,
    input  wire logic                  alu_zero
);

    typedef enum logic [3:0] {
        IDLE,
        FETCH_HI,
        FETCH_LO,
        DECODE,
        EXECUTE,
        WRITEBACK,
        LOAD_WB,
        STORE_WR,
        HALTED
    } state_t;

    typedef enum logic [1:0] {B_REG, B_IMM, B_ZERO} b_sel_t;
    typedef enum logic [1:0] {WD_ALU, WD_IMM, WD_MEM} wd_sel_t;

    state_t             state;
    cpu_pkg::addr_t     pc;
    cpu_pkg::addr_t     next_pc;
    cpu_pkg::instr_t    ir;
    logic               zero;
    b_sel_t             b_sel;
    wd_sel_t            wd_sel;

    cpu_pkg::opcode_t   op;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::data_t     imm;
    logic               is_arith;

    // Instruction fields
    assign op  = cpu_pkg::opcode_t'(ir[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
    assign rd  = ir[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
    assign rs  = ir[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
    assign rt  = ir[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
    assign imm = ir[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];

    // Only these update the zero flag; MOVRR also uses the ALU but leaves it
    assign is_arith = op inside {cpu_pkg::ADDRR, cpu_pkg::ADDI, cpu_pkg::SUBRR, cpu_pkg::SUBI};

    assign alu_subtract = (op == cpu_pkg::SUBRR) || (op == cpu_pkg::SUBI);
    assign halted       = (state == HALTED);
    assign wr_addr      = rd;

    always_comb begin
        case (b_sel)
            B_IMM:   alu_b = imm;
            B_ZERO:  alu_b = '0;
            default: alu_b = rd1_data;
        endcase
    end

    always_comb begin
        case (wd_sel)
            WD_IMM:  wr_data = imm;
            WD_MEM:  wr_data = mem_rdata;
            default: wr_data = alu_result;
        endcase
    end

    // JZR target was read from rd during DECODE
    always_comb begin
        next_pc = pc + cpu_pkg::addr_t'(2);
        if (zero && op == cpu_pkg::JZI) begin
            next_pc = imm;
        end
        if (zero && op == cpu_pkg::JZR) begin
            next_pc = rd0_data;
        end
    end

    // Memory and register file strobes per state
    always_comb begin
        mem_addr = pc;
        mem_re   = 1'b0;
        mem_we   = 1'b0;
        rd0_en   = 1'b0;
        rd0_addr = rd;
        rd1_en   = 1'b0;
        rd1_addr = rt;
        wr_en    = 1'b0;
        case (state)
            FETCH_HI: begin
                mem_re = 1'b1;
            end
            FETCH_LO: begin
                mem_addr = pc + cpu_pkg::addr_t'(1);
                mem_re   = 1'b1;
            end
            DECODE: begin
                // High byte is in ir already, so rd can be read early
                rd0_en = (op == cpu_pkg::JZR);
            end
            EXECUTE: begin
                case (op)
                    cpu_pkg::MOVIR: begin
                        wr_en = 1'b1;
                    end
                    cpu_pkg::MOVRR: begin
                        rd0_en   = 1'b1;
                        rd0_addr = rs;
                    end
                    cpu_pkg::LOAD: begin
                        mem_addr = imm;
                        mem_re   = 1'b1;
                    end
                    cpu_pkg::ADDRR, cpu_pkg::SUBRR: begin
                        rd0_en   = 1'b1;
                        rd0_addr = rs;
                        rd1_en   = 1'b1;
                    end
                    cpu_pkg::STORE, cpu_pkg::ADDI, cpu_pkg::SUBI: begin
                        rd0_en = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            WRITEBACK: begin
                wr_en = (op != cpu_pkg::STORE);
            end
            LOAD_WB: begin
                wr_en = 1'b1;
            end
            STORE_WR: begin
                mem_addr = imm;
                mem_we   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            pc     <= '0;
            zero   <= 1'b0;
            b_sel  <= B_REG;
            wd_sel <= WD_ALU;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        pc    <= '0;
                        state <= FETCH_HI;
                    end
                end
                FETCH_HI: state <= FETCH_LO;
                FETCH_LO: state <= DECODE;
                DECODE: begin
                    case (op)
                        cpu_pkg::ADDI, cpu_pkg::SUBI: b_sel <= B_IMM;
                        cpu_pkg::MOVRR:               b_sel <= B_ZERO;
                        default:                      b_sel <= B_REG;
                    endcase
                    case (op)
                        cpu_pkg::MOVIR: wd_sel <= WD_IMM;
                        cpu_pkg::LOAD:  wd_sel <= WD_MEM;
                        default:        wd_sel <= WD_ALU;
                    endcase
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    pc <= next_pc;
                    case (op)
                        cpu_pkg::LOAD:  state <= LOAD_WB;
                        cpu_pkg::HALT:  state <= HALTED;
                        cpu_pkg::STORE, cpu_pkg::MOVRR,
                        cpu_pkg::ADDRR, cpu_pkg::ADDI,
                        cpu_pkg::SUBRR, cpu_pkg::SUBI: state <= WRITEBACK;
                        default:        state <= FETCH_HI;
                    endcase
                end
                WRITEBACK: begin
                    if (op == cpu_pkg::STORE) begin
                        state <= STORE_WR;
                    end else begin
                        if (is_arith) begin
                            zero <= alu_zero;
                        end
                        state <= FETCH_HI;
                    end
                end
                LOAD_WB:  state <= FETCH_HI;
                STORE_WR: state <= FETCH_HI;
                HALTED:   state <= HALTED;
                default:  state <= IDLE;
            endcase
        end
    end

    // Instruction bytes and store data
    always_ff @(posedge clk) begin
        if (state == FETCH_LO) begin
            ir[cpu_pkg::INSTR_BITS-1 -: cpu_pkg::DATA_BITS] <= mem_rdata;
        end
        if (state == DECODE) begin
            ir[cpu_pkg::DATA_BITS-1:0] <= mem_rdata;
        end
        if (state == WRITEBACK && op == cpu_pkg::STORE) begin
            mem_wdata <= rd0_data;
        end
    end

    mem_dir_a: assert property (@(posedge clk) disable iff (reset) !(mem_re && mem_we))
        else $error("RAM read and write issued together");

endmodule

`default_nettype wire

/* logic/ram.sv */
`timescale 1ns/100ps
`default_nettype none

module ram (
    input  wire logic            clk,

    // Core port
    input  wire cpu_pkg::addr_t  addr,
    input  wire logic            re,
    input  wire logic            we,
    input  wire cpu_pkg::data_t  wdata,
    output cpu_pkg::data_t       rdata,

    // Host loader port
    input  wire logic            host_we,
    input  wire cpu_pkg::addr_t  host_addr,
    input  wire cpu_pkg::data_t  host_wdata
);

    cpu_pkg::data_t mem [cpu_pkg::MEM_BYTES];

    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read with data valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

    // Host loads only while the core is idle or halted
    single_writer_a: assert property (@(posedge clk) !(we && host_we))
        else $error("core and host write RAM in the same cycle");

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  rd0_en,
    input  wire cpu_pkg::reg_addr_t    rd0_addr,
    output cpu_pkg::data_t             rd0_data,

    input  wire logic                  rd1_en,
    input  wire cpu_pkg::reg_addr_t    rd1_addr,
    output cpu_pkg::data_t             rd1_data,

    input  wire logic                  wr_en,
    input  wire cpu_pkg::reg_addr_t    wr_addr,
    input  wire cpu_pkg::data_t        wr_data
);

    cpu_pkg::data_t regs [cpu_pkg::REG_COUNT];

    // Read ports hold their last value until enabled again
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            rd0_data <= '0;
            rd1_data <= '0;
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            // A read in the same cycle as a write sees the old value
            if (rd0_en) begin
                rd0_data <= regs[rd0_addr];
            end
            if (rd1_en) begin
                rd1_data <= regs[rd1_addr];
            end
        end
    end

    // The execution unit must present a clean index with every enable
    addr_known_a: assert property (@(posedge clk) disable iff (reset)
        !(rd0_en && $isunknown(rd0_addr)) &&
        !(rd1_en && $isunknown(rd1_addr)) &&
        !(wr_en && $isunknown(wr_addr)))
        else $error("register address unknown while enabled");

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::data_t a,
    input  wire cpu_pkg::data_t b,
    input  wire logic           subtract,
    output cpu_pkg::data_t      result,
    output logic                zero
);

    cpu_pkg::data_t b_eff;

    // Subtraction as a plus the two's complement of b
    assign b_eff = subtract ? cpu_pkg::data_t'(~b) : b;

    // Carry-in supplies the +1 of the complement and the sum wraps at 256
    assign result = a + b_eff + cpu_pkg::data_t'(subtract);

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Datapath sizes
    localparam int DATA_BITS     = 8;
    localparam int ADDR_BITS     = 8;
    localparam int REG_ADDR_BITS = 3;
    localparam int REG_COUNT     = 8;
    localparam int INSTR_BITS    = 2 * DATA_BITS;
    localparam int MEM_BYTES     = 1 << ADDR_BITS;

    typedef logic [DATA_BITS-1:0]     data_t;
    typedef logic [ADDR_BITS-1:0]     addr_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [INSTR_BITS-1:0]    instr_t;

    // Codes 11 to 14 are unassigned and run as NOP
    typedef enum logic [3:0] {
        MOVIR = 4'd0,
        MOVRR = 4'd1,
        LOAD  = 4'd2,
        STORE = 4'd3,
        ADDRR = 4'd4,
        ADDI  = 4'd5,
        SUBRR = 4'd6,
        SUBI  = 4'd7,
        JZI   = 4'd8,
        JZR   = 4'd9,
        NOP   = 4'd10,
        HALT  = 4'd15
    } opcode_t;

    // Instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RD_MSB     = 10;
    localparam int RD_LSB     = 8;
    localparam int RS_MSB     = 6;
    localparam int RS_LSB     = 4;
    localparam int RT_MSB     = 2;
    localparam int RT_LSB     = 0;

    // Immediate and memory address share the low byte
    localparam int IMM_MSB    = 7;
    localparam int IMM_LSB    = 0;

endpackage

`default_nettype wire
